// ==== all.f ====
+incdir+verilog
verilog/snake_pkg.sv
verilog/game_fsm.sv
verilog/snake_body.sv
verilog/apple_gen.sv
verilog/pixel_painter.sv
verilog/snake_top.sv
sim/snake_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the snake testbench with Verilator, run it, then look for the pass line
cd "$(dirname "$0")" \
	&& verilator --binary --timing --assert -Wno-fatal --top-module snake_tb \
		-f all.f -o snake_sim > build.log 2>&1 \
	&& ./obj_dir/snake_sim > sim.log 2>&1 \
	&& grep -qx "Simulation completed successfully" sim.log \
	&& echo "PASS" \
	|| { echo "FAIL: see build.log and sim.log"; exit 1; }

// ==== sim/snake_tb.sv ====
`timescale 1ns/1ns
`include "snake_params.svh"

module snake_tb import snake_pkg::*; ();

	localparam int field_pixels = `SNAKE_FIELD_W * `SNAKE_FIELD_H;
	localparam int border_pixels = field_pixels
		- (`SNAKE_FIELD_W - 2 * `SNAKE_WALL) * (`SNAKE_FIELD_H - 2 * `SNAKE_WALL);
	// heads from the start x down to the wall edge, the next step hits the wall
	localparam int frames_per_game = `SNAKE_START_X - `SNAKE_WALL + 1;
	// clear at half throughput plus the wall scan, with room for long stalls
	localparam int frame_budget = 4 * field_pixels;
	localparam int cycle_limit = (frames_per_game + 2) * frame_budget;

	logic clk = 1'b0;
	logic rst;
	buttons_t buttons;
	pixel_t pixel;
	logic pixel_valid;
	logic pixel_ready = 1'b0;
	snake_len_t snake_len;
	logic game_over;

	// ready pattern source
	logic [15:0] ready_state = 16'd62;

	int errors = 0;
	int cycles = 0;
	logic started = 1'b0;

	// sink bookkeeping
	draw_phase_t sink_phase = ph_clear;
	int phase_count = 0;
	int frames = 0;
	int game_frames = 0;
	int pixel_count = 0;
	int seen_frame [field_pixels];
	logic held = 1'b0;
	pixel_t held_pixel;

	// apple shown this frame and the one before it
	int frame_apple_x = 0;
	int frame_apple_y = 0;
	int frame_apple_colour = 0;
	int old_apple_x = 0;
	int old_apple_y = 0;
	int old_apple_colour = 0;

	// snake model, straight left run
	int exp_head = 0;
	int exp_len = 0;
	int exp_colour = 0;
	// head x as drawn by the dut in the latest frame
	int last_head = 0;

	snake_top #(
		.step_ticks(4)
	) i_dut (
		.clk(clk),
		.rst(rst),
		.buttons(buttons),
		.pixel(pixel),
		.pixel_valid(pixel_valid),
		.pixel_ready(pixel_ready),
		.snake_len(snake_len),
		.game_over(game_over)
	);

	initial
	begin
		forever
			#4 clk = ~clk;
	end

	// 16 bit galois, taps 16,14,13,11
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
	endfunction

	function automatic int apple_colour_for(input int x);
		int low;
		low = x % 8;
		return (low == 0) ? 4 : low;
	endfunction

	function automatic logic on_border(input int x, input int y);
		return (x < `SNAKE_WALL) || (x >= `SNAKE_FIELD_W - `SNAKE_WALL)
			|| (y < `SNAKE_WALL) || (y >= `SNAKE_FIELD_H - `SNAKE_WALL);
	endfunction

	task automatic expect_eq(input string name, input int expected, input int actual);
		assert (expected == actual)
		else
		begin
			$display("** Error %s at %0t: expected %0d, actual %0d",
				name, $time, expected, actual);
			errors++;
		end
	endtask

	task automatic enter_phase(input draw_phase_t ph);
		sink_phase = ph;
		phase_count = 0;
	endtask

	// model update at the head of each drawn snake
	task automatic start_snake(input int px, input int py);
		if (game_frames == 0)
		begin
			exp_head = `SNAKE_START_X;
			exp_len = `SNAKE_START_LEN;
			exp_colour = int'(col_green);
		end
		else
		begin
			exp_head = exp_head - 1;
			// head landed on last frame's apple
			if (exp_head == old_apple_x && `SNAKE_START_Y == old_apple_y)
			begin
				exp_len = exp_len + old_apple_colour;
				if (exp_len > `SNAKE_MAX_LEN)
					exp_len = `SNAKE_MAX_LEN;
				exp_colour = old_apple_colour;
			end
		end
		expect_eq("snake length", exp_len, int'(snake_len));
		assert (!on_border(px, py))
		else
		begin
			$display("** Error head drawn on the wall at x %0d y %0d", px, py);
			errors++;
		end
		last_head = px;
	endtask

	// one transferred pixel, sorted by frame position
	task automatic take_pixel(input pixel_t p);
		int px;
		int py;
		int pos;
		px = int'(p.x);
		py = int'(p.y);
		pos = px * `SNAKE_FIELD_H + py;
		pixel_count++;
		case (sink_phase)
			ph_clear:
			begin
				// y runs fastest
				expect_eq("clear x", phase_count / `SNAKE_FIELD_H, px);
				expect_eq("clear y", phase_count % `SNAKE_FIELD_H, py);
				expect_eq("clear colour", int'(col_black), int'(p.colour));
				phase_count++;
				if (phase_count == field_pixels)
					enter_phase(ph_walls);
			end
			ph_walls:
			begin
				expect_eq("wall colour", int'(col_blue), int'(p.colour));
				assert (px < `SNAKE_FIELD_W && py < `SNAKE_FIELD_H && on_border(px, py))
				else
				begin
					$display("** Error wall pixel at x %0d y %0d is off the border", px, py);
					errors++;
				end
				if (px < `SNAKE_FIELD_W && py < `SNAKE_FIELD_H)
				begin
					assert (seen_frame[pos] != frames)
					else
					begin
						$display("** Error wall pixel at x %0d y %0d sent twice", px, py);
						errors++;
					end
					seen_frame[pos] = frames;
				end
				// distinct border pixels, so all of them once
				phase_count++;
				if (phase_count == border_pixels)
					enter_phase(ph_apple);
			end
			ph_apple:
			begin
				assert (px >= 2 && px <= 101 && py >= 2 && py <= 101)
				else
				begin
					$display("** Error apple at x %0d y %0d is out of range", px, py);
					errors++;
				end
				expect_eq("apple colour", apple_colour_for(px), int'(p.colour));
				old_apple_x = frame_apple_x;
				old_apple_y = frame_apple_y;
				old_apple_colour = frame_apple_colour;
				frame_apple_x = px;
				frame_apple_y = py;
				frame_apple_colour = int'(p.colour);
				enter_phase(ph_snake);
			end
			default:
			begin
				if (phase_count == 0)
					start_snake(px, py);
				expect_eq("snake x", exp_head + phase_count, px);
				expect_eq("snake y", `SNAKE_START_Y, py);
				expect_eq("snake colour", exp_colour, int'(p.colour));
				phase_count++;
				if (phase_count == exp_len)
				begin
					frames++;
					game_frames++;
					enter_phase(ph_clear);
				end
			end
		endcase
	endtask

	always @(posedge clk)
	begin
		ready_state = lfsr_next(ready_state);
		pixel_ready <= ready_state[0];
	end

	// sink samples mid cycle, away from the active edge
	always @(negedge clk)
	begin
		if (!rst)
		begin
			if (!started)
			begin
				assert (!pixel_valid && !game_over)
				else
				begin
					$display("** Error output active before the start button was released");
					errors++;
				end
			end
			if (game_over)
			begin
				assert (!pixel_valid)
				else
				begin
					$display("** Error pixel stream still running after game over");
					errors++;
				end
			end
			if (held)
			begin
				assert (pixel_valid)
				else
				begin
					$display("** Error pixel_valid dropped before a transfer");
					errors++;
				end
				expect_eq("stalled pixel", int'(held_pixel), int'(pixel));
			end
			held = pixel_valid && !pixel_ready;
			held_pixel = pixel;
			if (pixel_valid && pixel_ready)
				take_pixel(pixel);
		end
	end

	// start press and release, any button does
	task automatic press_and_release();
		@(posedge clk);
		buttons.left <= 1'b1;
		game_frames = 0;
		repeat (5) @(posedge clk);
		buttons <= '0;
		started = 1'b1;
	endtask

	initial
	begin
		while (cycles < cycle_limit)
		begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout: run did not finish within %0d cycles, %0d errors so far",
			cycles, errors);
		$display("Simulation failed");
		$finish;
	end

	initial
	begin
		foreach (seen_frame[i])
			seen_frame[i] = -1;
		rst = 1'b1;
		buttons = '0;
		repeat (3) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		expect_eq("reset length", `SNAKE_START_LEN, int'(snake_len));
		expect_eq("reset game over", 0, int'(game_over));
		// idle stretch, nothing may come out
		repeat (20) @(posedge clk);
		press_and_release();
		// snake runs left into the wall with no button held
		while (!game_over)
			@(negedge clk);
		@(posedge clk);
		expect_eq("frames per game", frames_per_game, game_frames);
		expect_eq("last head x", `SNAKE_WALL, last_head);
		expect_eq("sink position at game over", 0, phase_count);
		repeat (40) @(posedge clk);
		// restart and let one frame through
		press_and_release();
		while (game_frames == 0)
			@(posedge clk);
		@(negedge clk);
		expect_eq("restart length", `SNAKE_START_LEN, int'(snake_len));
		expect_eq("restart game over", 0, int'(game_over));
		$display("snake_tb: %0d frames, %0d pixels, %0d cycles, %0d errors",
			frames, pixel_count, cycles, errors);
		if (errors == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

// ==== verilog/apple_gen.sv ====
`timescale 1ns/1ns
`include "snake_params.svh"

module apple_gen import snake_pkg::*; (
	input logic clk,
	input logic rst,
	input logic new_apple,
	output coord_x_t apple_x,
	output coord_y_t apple_y,
	output colour_t apple_colour
);

	logic [13:0] lfsr;
	logic feedback;
	logic [6:0] raw_x;
	logic [6:0] raw_y;
	coord_x_t next_x;
	coord_y_t next_y;

	// x^14 + x^13 + x^12 + x^2 + 1, maximal length
	assign feedback = lfsr[13] ^ lfsr[12] ^ lfsr[11] ^ lfsr[1];

	always_ff @(posedge clk)
	begin
		if (rst)
			lfsr <= 14'h2a5;
		else
			lfsr <= {lfsr[12:0], feedback};
	end

	// fold 100..127 back into range, then shift off the wall
	assign raw_x = (lfsr[6:0] >= 7'(`SNAKE_APPLE_SPAN)) ?
		lfsr[6:0] - 7'(`SNAKE_APPLE_SPAN) : lfsr[6:0];
	assign raw_y = (lfsr[13:7] >= 7'(`SNAKE_APPLE_SPAN)) ?
		lfsr[13:7] - 7'(`SNAKE_APPLE_SPAN) : lfsr[13:7];
	assign next_x = coord_x_t'(raw_x) + coord_x_t'(`SNAKE_APPLE_BASE);
	assign next_y = raw_y + coord_y_t'(`SNAKE_APPLE_BASE);

	always_ff @(posedge clk)
	begin
		if (new_apple)
		begin
			apple_x <= next_x;
			apple_y <= next_y;
			// black apple would vanish, use red
			if (next_x[2:0] == 3'd0)
				apple_colour <= 3'd4;
			else
				apple_colour <= next_x[2:0];
		end
	end

endmodule

// ==== verilog/game_fsm.sv ====
`timescale 1ns/1ns

module game_fsm import snake_pkg::*; #(
	parameter int step_ticks = 4
) (
	input logic clk,
	input logic rst,
	input buttons_t buttons,
	input logic draw_done,
	input logic check_done,
	input logic hit,
	input logic ate,
	input colour_t apple_colour,
	output logic draw_start,
	output draw_phase_t draw_phase,
	output logic load,
	output logic step,
	output logic check_start,
	output logic new_apple,
	output dir_t dir,
	output colour_t grow_by,
	output logic game_over
);

	localparam int cnt_w = (step_ticks > 1) ? $clog2(step_ticks) : 1;
	localparam logic [cnt_w-1:0] delay_last = cnt_w'(step_ticks - 1);

	game_state_t state;
	logic [cnt_w-1:0] delay_cnt;
	logic any_button;
	dir_t next_dir;

	assign any_button = |buttons;

	// first held button wins, a reversal is ignored
	always_comb
	begin
		next_dir = dir;
		if (buttons.left && dir != dir_right)
			next_dir = dir_left;
		else if (buttons.right && dir != dir_left)
			next_dir = dir_right;
		else if (buttons.down && dir != dir_up)
			next_dir = dir_down;
		else if (buttons.up && dir != dir_down)
			next_dir = dir_up;
	end

	// pulses are raised on the edge that enters a state
	always_ff @(posedge clk)
	begin
		draw_start <= 1'b0;
		load <= 1'b0;
		step <= 1'b0;
		check_start <= 1'b0;
		new_apple <= 1'b0;
		grow_by <= '0;
		if (rst)
		begin
			state <= st_idle;
			draw_phase <= ph_clear;
			dir <= dir_left;
			delay_cnt <= '0;
			game_over <= 1'b0;
		end
		else
		begin
			case (state)
				st_idle:
					if (any_button)
						state <= st_start_hold;
				// game begins once every button is let go
				st_start_hold:
					if (!any_button)
					begin
						load <= 1'b1;
						dir <= dir_left;
						state <= st_load;
					end
				st_load:
				begin
					new_apple <= 1'b1;
					state <= st_make_apple;
				end
				st_make_apple:
				begin
					draw_start <= 1'b1;
					draw_phase <= ph_clear;
					state <= st_clear;
				end
				st_clear:
					if (draw_done)
					begin
						draw_start <= 1'b1;
						draw_phase <= ph_walls;
						state <= st_walls;
					end
				st_walls:
					if (draw_done)
					begin
						draw_start <= 1'b1;
						draw_phase <= ph_apple;
						state <= st_apple;
					end
				st_apple:
					if (draw_done)
					begin
						draw_start <= 1'b1;
						draw_phase <= ph_snake;
						state <= st_snake;
					end
				st_snake:
					if (draw_done)
					begin
						delay_cnt <= '0;
						state <= st_delay;
					end
				// frame pacing, then the step goes out with the new direction
				st_delay:
					if (delay_cnt == delay_last)
					begin
						dir <= next_dir;
						step <= 1'b1;
						state <= st_move;
					end
					else
						delay_cnt <= delay_cnt + 1'b1;
				// body applies the step this cycle, scan starts after
				st_move:
				begin
					check_start <= 1'b1;
					state <= st_check;
				end
				st_check:
					if (check_done)
					begin
						if (hit)
						begin
							game_over <= 1'b1;
							state <= st_dead;
						end
						else if (ate)
						begin
							// growth and the next apple land together
							grow_by <= apple_colour;
							new_apple <= 1'b1;
							state <= st_make_apple;
						end
						else
						begin
							draw_start <= 1'b1;
							draw_phase <= ph_clear;
							state <= st_clear;
						end
					end
				st_dead:
					if (any_button)
					begin
						game_over <= 1'b0;
						state <= st_start_hold;
					end
				default:
					state <= st_idle;
			endcase
		end
	end

endmodule

// ==== verilog/pixel_painter.sv ====
`timescale 1ns/1ns
`include "snake_params.svh"

module pixel_painter import snake_pkg::*; (
	input logic clk,
	input logic rst,
	input logic draw_start,
	input draw_phase_t draw_phase,
	input coord_x_t apple_x,
	input coord_y_t apple_y,
	input colour_t apple_colour,
	input coord_x_t seg_x,
	input coord_y_t seg_y,
	input colour_t seg_colour,
	input snake_len_t len,
	output snake_len_t seg_idx,
	output logic draw_done,
	output pixel_t pixel,
	output logic pixel_valid,
	input logic pixel_ready
);

	logic active;
	coord_x_t ras_x;
	coord_y_t ras_y;
	logic on_border;
	logic raster_end;
	logic last;
	logic advance;

	assign on_border = (ras_x < `SNAKE_WALL) || (ras_x >= `SNAKE_FIELD_W - `SNAKE_WALL)
		|| (ras_y < `SNAKE_WALL) || (ras_y >= `SNAKE_FIELD_H - `SNAKE_WALL);
	assign raster_end = (ras_x == `SNAKE_FIELD_W - 1) && (ras_y == `SNAKE_FIELD_H - 1);

	// candidate pixel, held while stalled since counters only move on advance
	always_comb
	begin
		pixel.x = ras_x;
		pixel.y = ras_y;
		pixel.colour = col_black;
		last = raster_end;
		case (draw_phase)
			ph_walls:
				pixel.colour = col_blue;
			ph_apple:
			begin
				pixel.x = apple_x;
				pixel.y = apple_y;
				pixel.colour = apple_colour;
				last = 1'b1;
			end
			ph_snake:
			begin
				pixel.x = seg_x;
				pixel.y = seg_y;
				pixel.colour = seg_colour;
				last = (seg_idx == len - 1'b1);
			end
			default:
				pixel.colour = col_black;
		endcase
	end

	// walls phase hides interior positions
	assign pixel_valid = active && (draw_phase != ph_walls || on_border);

	// transfer, or a skipped interior wall position
	assign advance = active
		&& ((pixel_valid && pixel_ready) || (draw_phase == ph_walls && !on_border));

	always_ff @(posedge clk)
	begin
		draw_done <= 1'b0;
		if (rst)
		begin
			active <= 1'b0;
			ras_x <= '0;
			ras_y <= '0;
			seg_idx <= '0;
		end
		else if (draw_start)
		begin
			active <= 1'b1;
			ras_x <= '0;
			ras_y <= '0;
			seg_idx <= '0;
		end
		else if (advance)
		begin
			if (last)
			begin
				active <= 1'b0;
				draw_done <= 1'b1;
			end
			else if (draw_phase == ph_snake)
				seg_idx <= seg_idx + 1'b1;
			// y runs fastest, x steps at the bottom of each column
			else if (ras_y == `SNAKE_FIELD_H - 1)
			begin
				ras_y <= '0;
				ras_x <= ras_x + 1'b1;
			end
			else
				ras_y <= ras_y + 1'b1;
		end
	end

endmodule

// ==== verilog/snake_body.sv ====
`timescale 1ns/1ns
`include "snake_params.svh"

module snake_body import snake_pkg::*; (
	input logic clk,
	input logic rst,
	input logic load,
	input logic step,
	input logic check_start,
	input dir_t dir,
	input colour_t grow_by,
	input coord_x_t apple_x,
	input coord_y_t apple_y,
	input snake_len_t seg_idx,
	output coord_x_t seg_x,
	output coord_y_t seg_y,
	output colour_t seg_colour,
	output snake_len_t len,
	output logic ate,
	output logic hit,
	output logic check_done
);

	localparam int idx_w = $clog2(`SNAKE_MAX_LEN);

	// index 0 is the head
	coord_x_t body_x [`SNAKE_MAX_LEN];
	coord_y_t body_y [`SNAKE_MAX_LEN];
	colour_t body_colour;
	coord_x_t head_x;
	coord_y_t head_y;
	snake_len_t grown;
	snake_len_t chk_idx;
	logic busy;
	logic self_hit;
	logic wall_hit;

	// next head one pixel along dir
	always_comb
	begin
		head_x = body_x[0];
		head_y = body_y[0];
		case (dir)
			dir_left: head_x = body_x[0] - 1'b1;
			dir_right: head_x = body_x[0] + 1'b1;
			dir_down: head_y = body_y[0] + 1'b1;
			default: head_y = body_y[0] - 1'b1;
		endcase
	end

	// whole register shifts, so slots past len keep the old trail for growth
	always_ff @(posedge clk)
	begin
		if (load)
		begin
			for (int i = 0; i < `SNAKE_MAX_LEN; i++)
			begin
				body_x[i] <= coord_x_t'(`SNAKE_START_X + i);
				body_y[i] <= coord_y_t'(`SNAKE_START_Y);
			end
		end
		else if (step)
		begin
			for (int i = `SNAKE_MAX_LEN - 1; i > 0; i--)
			begin
				body_x[i] <= body_x[i-1];
				body_y[i] <= body_y[i-1];
			end
			body_x[0] <= head_x;
			body_y[0] <= head_y;
		end
	end

	assign grown = len + snake_len_t'(grow_by);

	// scan compare and wall band test
	assign self_hit = (body_x[chk_idx[idx_w-1:0]] == body_x[0])
		&& (body_y[chk_idx[idx_w-1:0]] == body_y[0]);
	assign wall_hit = (body_x[0] < `SNAKE_WALL)
		|| (body_x[0] >= `SNAKE_FIELD_W - `SNAKE_WALL)
		|| (body_y[0] < `SNAKE_WALL)
		|| (body_y[0] >= `SNAKE_FIELD_H - `SNAKE_WALL);

	always_ff @(posedge clk)
	begin
		check_done <= 1'b0;
		if (rst)
		begin
			len <= `SNAKE_START_LEN;
			body_colour <= col_green;
			busy <= 1'b0;
			chk_idx <= '0;
			hit <= 1'b0;
		end
		else
		begin
			if (load)
			begin
				len <= `SNAKE_START_LEN;
				body_colour <= col_green;
			end
			else if (grow_by != '0)
			begin
				// saturate at the register depth
				if (grown > snake_len_t'(`SNAKE_MAX_LEN))
					len <= `SNAKE_MAX_LEN;
				else
					len <= grown;
				body_colour <= grow_by;
			end
			// segments 1 .. len-1, then one cycle for the wall
			if (check_start)
			begin
				busy <= 1'b1;
				chk_idx <= 6'd1;
				hit <= 1'b0;
			end
			else if (busy)
			begin
				if (chk_idx < len)
				begin
					if (self_hit)
						hit <= 1'b1;
					chk_idx <= chk_idx + 1'b1;
				end
				else
				begin
					if (wall_hit)
						hit <= 1'b1;
					busy <= 1'b0;
					check_done <= 1'b1;
				end
			end
		end
	end

	assign ate = (body_x[0] == apple_x) && (body_y[0] == apple_y);

	// read port for the painter
	assign seg_x = body_x[seg_idx[idx_w-1:0]];
	assign seg_y = body_y[seg_idx[idx_w-1:0]];
	assign seg_colour = body_colour;

endmodule

// ==== verilog/snake_params.svh ====
`ifndef SNAKE_PARAMS_SVH
`define SNAKE_PARAMS_SVH

// playfield in pixels
`define SNAKE_FIELD_W 160
`define SNAKE_FIELD_H 120

// border wall thickness
`define SNAKE_WALL 2

// depth of the segment shift register
`define SNAKE_MAX_LEN 32

// snake after a load, head at the left end
`define SNAKE_START_X 30
`define SNAKE_START_Y 20
`define SNAKE_START_LEN 5

// apple coordinates fall in base .. base + span - 1
`define SNAKE_APPLE_SPAN 100
`define SNAKE_APPLE_BASE 2

`endif

// ==== verilog/snake_pkg.sv ====
package snake_pkg;

	// screen coordinates
	typedef logic [7:0] coord_x_t;
	typedef logic [6:0] coord_y_t;

	// 1 bit per rgb channel
	typedef logic [2:0] colour_t;

	// segment count, doubles as the score
	typedef logic [5:0] snake_len_t;

	localparam colour_t col_black = 3'd0;
	localparam colour_t col_blue = 3'd1;
	localparam colour_t col_green = 3'd2;

	typedef enum logic [1:0] {dir_left, dir_right, dir_down, dir_up} dir_t;

	typedef enum logic [3:0] {
		st_idle, st_start_hold, st_load, st_make_apple,
		st_clear, st_walls, st_apple, st_snake,
		st_delay, st_move, st_check, st_dead
	} game_state_t;

	typedef enum logic [1:0] {ph_clear, ph_walls, ph_apple, ph_snake} draw_phase_t;

	typedef struct packed {
		coord_x_t x;
		coord_y_t y;
		colour_t colour;
	} pixel_t;

	// level sensitive, high while held
	typedef struct packed {
		logic left;
		logic right;
		logic down;
		logic up;
	} buttons_t;

endpackage

// ==== verilog/snake_top.sv ====
`timescale 1ns/1ns

module snake_top import snake_pkg::*; #(
	parameter int step_ticks = 4
) (
	input logic clk,
	input logic rst,
	input buttons_t buttons,
	output pixel_t pixel,
	output logic pixel_valid,
	input logic pixel_ready,
	output snake_len_t snake_len,
	output logic game_over
);

	// fsm to painter
	logic draw_start;
	draw_phase_t draw_phase;
	logic draw_done;

	// fsm to body
	logic load;
	logic step;
	logic check_start;
	dir_t dir;
	colour_t grow_by;
	logic check_done;
	logic hit;
	logic ate;

	// apple state
	logic new_apple;
	coord_x_t apple_x;
	coord_y_t apple_y;
	colour_t apple_colour;

	// segment read port
	snake_len_t seg_idx;
	coord_x_t seg_x;
	coord_y_t seg_y;
	colour_t seg_colour;

	game_fsm #(
		.step_ticks(step_ticks)
	) i_fsm (
		.clk(clk),
		.rst(rst),
		.buttons(buttons),
		.draw_done(draw_done),
		.check_done(check_done),
		.hit(hit),
		.ate(ate),
		.apple_colour(apple_colour),
		.draw_start(draw_start),
		.draw_phase(draw_phase),
		.load(load),
		.step(step),
		.check_start(check_start),
		.new_apple(new_apple),
		.dir(dir),
		.grow_by(grow_by),
		.game_over(game_over)
	);

	snake_body i_body (
		.clk(clk),
		.rst(rst),
		.load(load),
		.step(step),
		.check_start(check_start),
		.dir(dir),
		.grow_by(grow_by),
		.apple_x(apple_x),
		.apple_y(apple_y),
		.seg_idx(seg_idx),
		.seg_x(seg_x),
		.seg_y(seg_y),
		.seg_colour(seg_colour),
		.len(snake_len),
		.ate(ate),
		.hit(hit),
		.check_done(check_done)
	);

	apple_gen i_apple (
		.clk(clk),
		.rst(rst),
		.new_apple(new_apple),
		.apple_x(apple_x),
		.apple_y(apple_y),
		.apple_colour(apple_colour)
	);

	pixel_painter i_painter (
		.clk(clk),
		.rst(rst),
		.draw_start(draw_start),
		.draw_phase(draw_phase),
		.apple_x(apple_x),
		.apple_y(apple_y),
		.apple_colour(apple_colour),
		.seg_x(seg_x),
		.seg_y(seg_y),
		.seg_colour(seg_colour),
		.len(snake_len),
		.seg_idx(seg_idx),
		.draw_done(draw_done),
		.pixel(pixel),
		.pixel_valid(pixel_valid),
		.pixel_ready(pixel_ready)
	);

endmodule
